//--- files.f
+incdir+src
src/gf_pkg.sv
src/bch_pkg.sv
src/bch_syndrome.sv
src/bch_chien.sv
src/bch_delay.sv
src/bch_error_dec.sv
src/bch_dec_top.sv
sim/bch_dec_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the BCH decoder testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module bch_dec_tb -o bch_dec_sim

# the log decides the result, so a nonzero exit from the run is tolerated here
./obj_dir/bch_dec_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
	echo "simulation failed"
	exit 1
fi

if ! grep -q "PASS: all tests" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi

echo "simulation passed"

//--- sim/bch_dec_tb.sv
// BCH (15,7) decoder testbench.
// random codewords with 0 to 3 injected errors, checked cycle by cycle
// against a behavioral encoder, syndrome and decision model.

`default_nettype none

`include "bch_consts.svh"

module bch_dec_tb;

	import bch_pkg::*;

	localparam int N_WORDS = 200;
	localparam int RESET_CYCLES = 10;
	localparam int IDLE_CYCLES = 4;
	// start to first output, and start to start when back to back.
	localparam int LAT = 2 + `BCH_PIPE_STAGES;
	localparam int START_GAP = 17;
	// all searches plus slack for reset, the last search and the idle tail.
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_WORDS * START_GAP + 590;
	localparam int UNCORR = `BCH_T + 1;
	// x^8 + x^7 + x^6 + x^4 + 1.
	localparam logic [8:0] GEN_POLY = 9'h1d1;

	logic         clk;
	logic         rst_n;
	logic         start;
	bch_word_t    rx_word;
	logic         ready;
	logic         out_bit;
	logic         out_err;
	bch_err_cnt_t err_count;
	logic         first;
	logic         last;
	logic         valid;

	integer seed;
	int     cyc;
	int     n_started;
	int     out_idx;
	int     last_start;

	// antilog and log tables of GF(2^4).
	logic [`BCH_M-1:0] gf_exp [`BCH_N];
	int                gf_log [16];

	// per word, the model's view of what the decoder must produce.
	int        start_cyc [N_WORDS];
	int        inj_count [N_WORDS];
	int        pred_cnt [N_WORDS];
	bch_word_t code_word [N_WORDS];
	bch_word_t inj_mask [N_WORDS];
	bch_word_t rx_copy [N_WORDS];
	bch_word_t flip_mask [N_WORDS];

	bch_dec_top dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.rx_word(rx_word),
		.ready(ready),
		.out_bit(out_bit),
		.out_err(out_err),
		.err_count(err_count),
		.first(first),
		.last(last),
		.valid(valid)
	);

	always #10 clk = ~clk;

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("Fail at time %0t: %s expected %0d, got %0d", $time, name, expected,
				actual);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	// powers of alpha by repeated shift and reduce by x^4 + x + 1.
	task automatic build_field_tables();
		logic [4:0] v;
		v = 5'd1;
		for (int i = 0; i < `BCH_N; i++) begin
			gf_exp[i] = v[3:0];
			gf_log[v[3:0]] = i;
			v = v << 1;
			if (v[4])
				v = v ^ 5'h13;
		end
		gf_log[0] = 0;
	endtask

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// multiply through the log tables.
	function automatic logic [`BCH_M-1:0] field_mul(input logic [`BCH_M-1:0] a,
			input logic [`BCH_M-1:0] b);
		if (a == '0 || b == '0)
			return '0;
		return gf_exp[(gf_log[a] + gf_log[b]) % `BCH_N];
	endfunction

	function automatic int classify(input logic [`BCH_M-1:0] a, input logic [`BCH_M-1:0] b);
		if (a == '0 && b == '0)
			return 0;
		if (a == '0)
			return UNCORR;
		if (b == field_mul(field_mul(a, a), a))
			return 1;
		return 2;
	endfunction

	// systematic encoding, parity is the remainder of data * x^8 by the generator.
	function automatic bch_word_t encode_word(input logic [`BCH_K-1:0] data);
		bch_word_t rem;
		rem = {data, (`BCH_N - `BCH_K)'(0)};
		for (int i = `BCH_N - 1; i >= `BCH_N - `BCH_K; i--) begin
			if (rem[i])
				rem = rem ^ (`BCH_N'(GEN_POLY) << (i - (`BCH_N - `BCH_K)));
		end
		return {data, rem[`BCH_N-`BCH_K-1:0]};
	endfunction

	function automatic bch_syn_t syndromes(input bch_word_t w);
		bch_syn_t s;
		s = '0;
		for (int j = 0; j < `BCH_N; j++) begin
			if (w[j]) begin
				s.s1 = s.s1 ^ gf_exp[j];
				s.s3 = s.s3 ^ gf_exp[(3 * j) % `BCH_N];
			end
		end
		return s;
	endfunction

	// builds word idx and predicts count and flips from the unscaled syndromes.
	task automatic prepare_word(input int idx);
		bch_word_t mask;
		bch_word_t flips;
		bch_syn_t  syn;
		int        placed;
		int        p;
		int        cnt;
		code_word[idx] = encode_word(`BCH_K'(rand_below(1 << `BCH_K)));
		inj_count[idx] = idx % 4;
		mask = '0;
		placed = 0;
		while (placed < inj_count[idx]) begin
			p = rand_below(`BCH_N);
			if (!mask[p]) begin
				mask[p] = 1'b1;
				placed++;
			end
		end
		rx_copy[idx] = code_word[idx] ^ mask;
		syn = syndromes(rx_copy[idx]);
		cnt = classify(syn.s1, syn.s3);
		flips = '0;
		// flipping bit j adds alpha^j to S1 and alpha^3j to S3.
		for (int j = 0; j < `BCH_N; j++) begin
			if (cnt != UNCORR && classify(syn.s1 ^ gf_exp[j],
					syn.s3 ^ gf_exp[(3 * j) % `BCH_N]) < cnt)
				flips[j] = 1'b1;
		end
		inj_mask[idx] = mask;
		pred_cnt[idx] = cnt;
		flip_mask[idx] = flips;
	endtask

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT_CYCLES) begin
			$display("timeout: the decoder did not finish all words within %0d cycles",
				TIMEOUT_CYCLES);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	end

	// outputs are checked and inputs driven on the falling edge.
	always @(negedge clk) begin : monitor
		int j;
		int exp_valid;
		int exp_ready;
		exp_ready = 1;
		if (n_started > 0 && cyc - last_start >= 1 && cyc - last_start < START_GAP)
			exp_ready = 0;
		check_value("ready", exp_ready, int'(ready));
		exp_valid = 0;
		j = -1;
		if (out_idx < n_started) begin
			j = cyc - start_cyc[out_idx] - LAT;
			if (j >= 0 && j < `BCH_N)
				exp_valid = 1;
		end
		check_value("valid", exp_valid, int'(valid));
		check_value("first", int'(exp_valid == 1 && j == 0), int'(first));
		check_value("last", int'(exp_valid == 1 && j == `BCH_N - 1), int'(last));
		if (exp_valid == 1) begin
			check_value("err_count", pred_cnt[out_idx], int'(err_count));
			check_value("out_err", int'(flip_mask[out_idx][j]), int'(out_err));
			check_value("out_bit", int'(rx_copy[out_idx][j] ^ flip_mask[out_idx][j]),
				int'(out_bit));
			// up to two errors must restore the sent codeword exactly.
			if (inj_count[out_idx] <= `BCH_T) begin
				check_value("err_count", inj_count[out_idx], int'(err_count));
				check_value("out_err", int'(inj_mask[out_idx][j]), int'(out_err));
				check_value("out_bit", int'(code_word[out_idx][j]), int'(out_bit));
			end
			if (j == `BCH_N - 1)
				out_idx++;
		end else begin
			check_value("out_err", 0, int'(out_err));
		end
		start = 1'b0;
		if (ready && n_started < N_WORDS && cyc >= RESET_CYCLES + IDLE_CYCLES) begin
			prepare_word(n_started);
			rx_word = rx_copy[n_started];
			start = 1'b1;
			start_cyc[n_started] = cyc;
			last_start = cyc;
			n_started++;
		end
	end

	initial begin
		seed = 60227;
		cyc = 0;
		n_started = 0;
		out_idx = 0;
		last_start = 0;
		build_field_tables();
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		rx_word = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		wait (out_idx == N_WORDS);
		// a few idle cycles show ready back high and valid low.
		repeat (4) @(negedge clk);
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/bch_dec_top.sv
// BCH (15,7) double-error-correcting decoder.
// syndrome stage, position search and error decision, one bit out per cycle.

`default_nettype none

module bch_dec_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  bch_pkg::bch_word_t    rx_word,
	output logic                  ready,
	output logic                  out_bit,
	output logic                  out_err,
	output bch_pkg::bch_err_cnt_t err_count,
	output logic                  first,
	output logic                  last,
	output logic                  valid
);

	import bch_pkg::*;

	logic       start_acc;
	bch_syn_t   syn;
	bch_word_t  word;
	logic       syn_valid;
	bch_chien_t pos;
	bch_frame_t frame;
	bch_syn_t   syn_hold;

	// a start during a search is dropped.
	assign start_acc = start && ready;

	bch_syndrome u_syn (
		.clk(clk),
		.rst_n(rst_n),
		.start(start_acc),
		.rx_word(rx_word),
		.syn(syn),
		.word(word),
		.syn_valid(syn_valid)
	);

	bch_chien u_chien (
		.clk(clk),
		.rst_n(rst_n),
		.syn_valid(syn_valid),
		.syn(syn),
		.word(word),
		.ready(ready),
		.pos(pos),
		.frame(frame),
		.syn_hold(syn_hold)
	);

	bch_error_dec u_err (
		.clk(clk),
		.rst_n(rst_n),
		.pos(pos),
		.frame(frame),
		.syn_hold(syn_hold),
		.out_bit(out_bit),
		.out_err(out_err),
		.err_count(err_count),
		.first(first),
		.last(last),
		.valid(valid)
	);

	// the source must wait for ready.
	a_start_when_ready: assert property (
		@(posedge clk) disable iff (!rst_n) start |-> ready);

endmodule

`default_nettype wire

//--- src/bch_error_dec.sv
// BCH error decision.
// classifies the syndromes, flips each search position and keeps the flip
// when it lowers the error count, then corrects the bit.
// latency is BCH_PIPE_STAGES cycles from pos and frame.

`default_nettype none

`include "bch_consts.svh"

module bch_error_dec (
	input  logic                  clk,
	input  logic                  rst_n,
	input  bch_pkg::bch_chien_t   pos,
	input  bch_pkg::bch_frame_t   frame,
	input  bch_pkg::bch_syn_t     syn_hold,
	output logic                  out_bit,
	output logic                  out_err,
	output bch_pkg::bch_err_cnt_t err_count,
	output logic                  first,
	output logic                  last,
	output logic                  valid
);

	import gf_pkg::*;
	import bch_pkg::*;

	// stage a after the cube, stage b after the comparison.
	localparam int STAGES_A = (`BCH_PIPE_STAGES > 0) ? 1 : 0;
	localparam int STAGES_B = `BCH_PIPE_STAGES - STAGES_A;

	typedef struct packed {
		gf_elem_t power;
		gf_elem_t c3;
		logic     nz1;
		logic     nz3;
		logic     rx_bit;
	} pow_stage_t;

	typedef struct packed {
		logic err;
		logic rx_bit;
	} dec_stage_t;

	// 0 if both zero, 1 if b is a cubed, 2 otherwise, 3 if only b is set.
	function automatic bch_err_cnt_t err_class(input logic a_nz, input logic b_nz,
			input logic cube_eq);
		if (!a_nz)
			return b_nz ? ERR_UNCORR : bch_err_cnt_t'(0);
		return cube_eq ? bch_err_cnt_t'(1) : bch_err_cnt_t'(2);
	endfunction

	gf_elem_t     c1_flip;
	gf_elem_t     c3_flip;
	pow_stage_t   pow_d;
	pow_stage_t   pow_q;
	bch_err_cnt_t err_cnt;
	bch_err_cnt_t flip_cnt;
	dec_stage_t   dec_d;
	dec_stage_t   dec_q;
	bch_frame_t   frame_mid;
	bch_frame_t   frame_out;

	// held syndromes stay fixed for the whole search.
	assign err_cnt = err_class(|syn_hold.s1, |syn_hold.s3,
		gf_pow3(syn_hold.s1) == syn_hold.s3);

	// flipping bit j adds alpha^0 to both scaled syndromes.
	assign c1_flip = pos.c1 ^ gf_elem_t'(1);
	assign c3_flip = pos.c3 ^ gf_elem_t'(1);

	assign pow_d = '{
		power:  gf_pow3(c1_flip),
		c3:     c3_flip,
		nz1:    |c1_flip,
		nz3:    |c3_flip,
		rx_bit: pos.rx_bit
	};

	bch_delay #(.payload_t(pow_stage_t), .STAGES(STAGES_A)) u_pow_dly (
		.clk(clk),
		.rst_n(rst_n),
		.d(pow_d),
		.q(pow_q)
	);

	bch_delay #(.payload_t(bch_frame_t), .STAGES(STAGES_A)) u_frame_dly_a (
		.clk(clk),
		.rst_n(rst_n),
		.d(frame),
		.q(frame_mid)
	);

	assign flip_cnt = err_class(pow_q.nz1, pow_q.nz3, pow_q.power == pow_q.c3);

	// bit is in error if the flip lowers a correctable count.
	assign dec_d.err = frame_mid.valid && (err_cnt != ERR_UNCORR) && (flip_cnt < err_cnt);
	assign dec_d.rx_bit = pow_q.rx_bit;

	bch_delay #(.payload_t(dec_stage_t), .STAGES(STAGES_B)) u_dec_dly (
		.clk(clk),
		.rst_n(rst_n),
		.d(dec_d),
		.q(dec_q)
	);

	bch_delay #(.payload_t(bch_frame_t), .STAGES(STAGES_B)) u_frame_dly_b (
		.clk(clk),
		.rst_n(rst_n),
		.d(frame_mid),
		.q(frame_out)
	);

	assign out_err = dec_q.err;
	assign out_bit = dec_q.rx_bit ^ dec_q.err;
	assign err_count = err_cnt;

	assign first = frame_out.first;
	assign last = frame_out.last;
	assign valid = frame_out.valid;

endmodule

`default_nettype wire

//--- src/bch_delay.sv
// Generic delay line.
// STAGES registers of any payload type, cleared by reset.

`default_nettype none

module bch_delay #(
	parameter type payload_t = logic,
	parameter int STAGES = 1
) (
	input  logic     clk,
	input  logic     rst_n,
	input  payload_t d,
	output payload_t q
);

	if (STAGES == 0) begin : g_bypass
		// zero depth, straight through.
		assign q = d;
	end else begin : g_pipe
		payload_t pipe_q [STAGES];

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				for (int i = 0; i < STAGES; i++)
					pipe_q[i] <= '0;
			end else begin
				pipe_q[0] <= d;
				for (int i = 1; i < STAGES; i++)
					pipe_q[i] <= pipe_q[i-1];
			end
		end

		assign q = pipe_q[STAGES-1];
	end

endmodule

`default_nettype wire

//--- src/bch_chien.sv
// BCH position search.
// steps scaled syndromes and the received word through all 15 positions,
// one per cycle, with first, last and valid framing.

`default_nettype none

`include "bch_consts.svh"

module bch_chien (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                syn_valid,
	input  bch_pkg::bch_syn_t   syn,
	input  bch_pkg::bch_word_t  word,
	output logic                ready,
	output bch_pkg::bch_chien_t pos,
	output bch_pkg::bch_frame_t frame,
	output bch_pkg::bch_syn_t   syn_hold
);

	import gf_pkg::*;
	import bch_pkg::*;

	typedef logic [`BCH_M-1:0] cnt_t;

	localparam cnt_t CNT_LAST = cnt_t'(`BCH_N - 1);
	// per-step scale factors alpha^-1 and alpha^-3.
	localparam gf_elem_t ALPHA_INV1 = gf_alpha_pow(`BCH_N - 1);
	localparam gf_elem_t ALPHA_INV3 = gf_alpha_pow(`BCH_N - 3);

	logic      busy_q;
	cnt_t      cnt_q;
	gf_elem_t  c1_q;
	gf_elem_t  c3_q;
	bch_word_t word_q;

	// busy spans positions 0 to 14.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			cnt_q <= '0;
		end else if (syn_valid) begin
			busy_q <= 1'b1;
			cnt_q <= '0;
		end else if (busy_q) begin
			if (cnt_q == CNT_LAST) begin
				busy_q <= 1'b0;
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	// position 0 loads unscaled, then each step divides c1 by alpha
	// and c3 by alpha^3.
	always_ff @(posedge clk) begin
		if (syn_valid) begin
			c1_q <= syn.s1;
			c3_q <= syn.s3;
			word_q <= word;
			syn_hold <= syn;
		end else if (busy_q) begin
			c1_q <= gf_mul(c1_q, ALPHA_INV1);
			c3_q <= gf_mul(c3_q, ALPHA_INV3);
			// next bit drops into position 0.
			word_q <= word_q >> 1;
		end
	end

	assign pos = '{c1: c1_q, c3: c3_q, rx_bit: word_q[0]};

	assign frame = '{
		first: busy_q && (cnt_q == '0),
		last:  busy_q && (cnt_q == CNT_LAST),
		valid: busy_q
	};

	// low from the load strobe until the last position has gone out.
	assign ready = !busy_q && !syn_valid;

	a_no_load_while_busy: assert property (
		@(posedge clk) disable iff (!rst_n) syn_valid |-> !busy_q);

endmodule

`default_nettype wire

//--- src/bch_syndrome.sv
// BCH syndrome stage.
// computes S1 and S3 of the received word on start, one cycle latency.

`default_nettype none

`include "bch_consts.svh"

module bch_syndrome (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  bch_pkg::bch_word_t rx_word,
	output bch_pkg::bch_syn_t  syn,
	output bch_pkg::bch_word_t word,
	output logic               syn_valid
);

	import gf_pkg::*;
	import bch_pkg::*;

	bch_syn_t syn_next;

	// S1 sums alpha^j and S3 sums alpha^3j over the set bits.
	// powers are constants, so this unrolls into xor trees.
	always_comb begin
		syn_next = '0;
		for (int j = 0; j < `BCH_N; j++) begin
			if (rx_word[j]) begin
				syn_next.s1 ^= gf_alpha_pow(j);
				syn_next.s3 ^= gf_alpha_pow(3 * j);
			end
		end
	end

	// one-cycle strobe toward the search.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			syn_valid <= 1'b0;
		end else begin
			syn_valid <= start;
		end
	end

	// word travels beside its syndromes.
	always_ff @(posedge clk) begin
		if (start) begin
			syn <= syn_next;
			word <= rx_word;
		end
	end

endmodule

`default_nettype wire

//--- src/bch_pkg.sv
// BCH decoder types.
// received word, syndromes, search position, output framing and error count.

`default_nettype none

`include "bch_consts.svh"

package bch_pkg;

	// bit j is the coefficient of x^j.
	typedef logic [`BCH_N-1:0] bch_word_t;

	typedef struct packed {
		gf_pkg::gf_elem_t s1;
		gf_pkg::gf_elem_t s3;
	} bch_syn_t;

	// one search position j.
	// c1 is S1 * alpha^-j, c3 is S3 * alpha^-3j.
	typedef struct packed {
		gf_pkg::gf_elem_t c1;
		gf_pkg::gf_elem_t c3;
		logic rx_bit;
	} bch_chien_t;

	typedef struct packed {
		logic first;
		logic last;
		logic valid;
	} bch_frame_t;

	// 0, 1 or 2 errors, or more than T.
	typedef logic [1:0] bch_err_cnt_t;

	localparam bch_err_cnt_t ERR_UNCORR = bch_err_cnt_t'(`BCH_T + 1);

endpackage

`default_nettype wire

//--- src/gf_pkg.sv
// Galois field GF(2^4) arithmetic.
// element type and multiply, square, cube and constant alpha powers.
// field built on the primitive polynomial x^4 + x + 1.

`default_nettype none

`include "bch_consts.svh"

package gf_pkg;

	typedef logic [`BCH_M-1:0] gf_elem_t;

	// low terms of the primitive polynomial, x^4 folds back to x + 1.
	localparam gf_elem_t GF_POLY_LOW = gf_elem_t'(3);

	// multiply by alpha, shift left and reduce.
	function automatic gf_elem_t gf_xtime(input gf_elem_t a);
		return {a[`BCH_M-2:0], 1'b0} ^ (a[`BCH_M-1] ? GF_POLY_LOW : gf_elem_t'(0));
	endfunction

	// shift-and-add multiply, one partial product per bit of b.
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t acc;
		gf_elem_t sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < `BCH_M; i++) begin
			if (b[i])
				acc ^= sh;
			sh = gf_xtime(sh);
		end
		return acc;
	endfunction

	function automatic gf_elem_t gf_sq(input gf_elem_t a);
		return gf_mul(a, a);
	endfunction

	function automatic gf_elem_t gf_pow3(input gf_elem_t a);
		return gf_mul(gf_sq(a), a);
	endfunction

	// alpha^e for a constant exponent, folded modulo the field order.
	function automatic gf_elem_t gf_alpha_pow(input int e);
		gf_elem_t r;
		r = gf_elem_t'(1);
		for (int i = 0; i < (e % `BCH_N); i++)
			r = gf_xtime(r);
		return r;
	endfunction

endpackage

`default_nettype wire

//--- src/bch_consts.svh
// BCH (15,7) decoder constants.
// field and code sizes plus the decision pipeline depth.

`ifndef BCH_CONSTS_SVH
`define BCH_CONSTS_SVH

// field width, elements of GF(2^4).
`define BCH_M 4

// code length, 2^M - 1 bits per word.
`define BCH_N 15

// data bits carried in one codeword.
`define BCH_K 7

// correction power, double-error correcting.
`define BCH_T 2

// register stages in the decision path, 0 to 2.
// stage 1 follows the cube, stage 2 follows the comparison.
`define BCH_PIPE_STAGES 1

`endif
